//--- Makefile
TOP = tb_soc_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f soc_bus_top.f

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f soc_bus_top.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- data_ram.sv
`timescale 1ns/10ps

module data_ram import soc_bus_pkg::*; #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic        clk,
    input  dec_req_t    dec_i,
    output logic [31:0] rdata_o
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [31:0]   rdata_q;
    logic [AW-1:0] word_addr;
    logic          sel;

    assign word_addr = dec_i.word_index[AW-1:0];
    assign sel       = (dec_i.target == TGT_RAM);

    always_ff @(posedge clk) begin
        if (sel) begin
            if (dec_i.wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (dec_i.be[i]) begin
                        mem[word_addr][8*i +: 8] <= dec_i.wdata[8*i +: 8];
                    end
                end
            end
            // the whole word is read, lane masking happens in the result stage
            if (dec_i.rd) begin
                rdata_q <= mem[word_addr];
            end
        end
    end

    assign rdata_o = rdata_q;

    // the decoder only hands out in-range word indices
    a_ram_bounds: assert property (@(posedge clk)
        (dec_i.rd || dec_i.wr) && sel |-> 32'(dec_i.word_index) < RAM_WORDS);

endmodule

//--- dbus_decode.sv
`timescale 1ns/10ps

module dbus_decode import soc_bus_pkg::*; #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst_i,
    input  dbus_req_t req_i,
    output dec_req_t  dec_o
);

    dec_req_t dec_next;
    logic     in_ram;
    logic     in_io;

    assign in_ram = (req_i.addr.ram.region == REGION_RAM);
    assign in_io  = (req_i.addr.io.region == REGION_IO);

    always_comb begin
        dec_next.rd         = req_i.rd;
        dec_next.wr         = req_i.wr;
        dec_next.word_index = req_i.addr.ram.word_index;
        dec_next.reg_index  = req_i.addr.io.reg_index;
        dec_next.be         = req_i.be;
        dec_next.wdata      = req_i.wdata;

        // anything that does not land on a known target falls through to an error
        dec_next.target = TGT_NONE;
        if (in_ram) begin
            if (32'(req_i.addr.ram.word_index) < RAM_WORDS) begin
                dec_next.target = TGT_RAM;
            end
        end else if (in_io) begin
            case (req_i.addr.io.device)
                DEV_GPIO: dec_next.target = TGT_GPIO;
                DEV_TICK: dec_next.target = TGT_TICK;
                default:  dec_next.target = TGT_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dec_o <= dec_next;
        if (rst_i) begin
            dec_o.rd <= 1'b0;
            dec_o.wr <= 1'b0;
        end
    end

    // the master never issues a read and a write in the same cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst_i)
        !(req_i.rd && req_i.wr));

endmodule

//--- io_regs.sv
`timescale 1ns/10ps

module io_regs import soc_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  dec_req_t    dec_i,
    input  logic [31:0] gpio_i,
    output logic [31:0] rdata_o,
    output logic [15:0] leds_o,
    output logic        irq_o
);

    logic [31:0] gpio_out_q;
    logic [31:0] gpio_in_q;
    logic        tick_en_q;
    logic        tick_irq_q;
    logic [31:0] tick_count_q;
    logic [31:0] tick_cmp_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_word;
    logic        gpio_wr;
    logic        tick_wr;
    logic        tick_hit;

    assign gpio_wr  = dec_i.wr && (dec_i.target == TGT_GPIO);
    assign tick_wr  = dec_i.wr && (dec_i.target == TGT_TICK);
    assign tick_hit = tick_en_q && (tick_count_q == tick_cmp_q);

    always_ff @(posedge clk) begin
        gpio_in_q <= gpio_i;    // one stage of sampling on the input pins
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gpio_out_q <= '0;
        end else if (gpio_wr && dec_i.reg_index == REG_GPIO_OUT) begin
            gpio_out_q <= dec_i.wdata;  // be is ignored for io
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tick_en_q    <= 1'b0;
            tick_irq_q   <= 1'b0;
            tick_count_q <= '0;
            tick_cmp_q   <= '0;
        end else begin
            if (tick_wr && dec_i.reg_index == REG_TICK_COUNT) begin
                tick_count_q <= dec_i.wdata;
            end else if (tick_en_q) begin
                tick_count_q <= tick_count_q + 32'd1;
            end
            if (tick_wr && dec_i.reg_index == REG_TICK_CMP) begin
                tick_cmp_q <= dec_i.wdata;
            end
            if (tick_wr && dec_i.reg_index == REG_TICK_CTRL) begin
                tick_en_q <= dec_i.wdata[0];
                if (dec_i.wdata[1]) begin
                    tick_irq_q <= 1'b0;     // write one to clear
                end
            end
            // a match in the same cycle as a clear still sets the flag
            if (tick_hit) begin
                tick_irq_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (dec_i.target == TGT_GPIO) begin
            case (dec_i.reg_index)
                REG_GPIO_OUT: rd_word = gpio_out_q;
                REG_GPIO_IN:  rd_word = gpio_in_q;
                default:      rd_word = '0;
            endcase
        end else if (dec_i.target == TGT_TICK) begin
            case (dec_i.reg_index)
                REG_TICK_CTRL:  rd_word = {30'd0, tick_irq_q, tick_en_q};
                REG_TICK_COUNT: rd_word = tick_count_q;
                REG_TICK_CMP:   rd_word = tick_cmp_q;
                default:        rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.rd && (dec_i.target == TGT_GPIO || dec_i.target == TGT_TICK)) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata_o = rdata_q;
    assign leds_o  = gpio_out_q[15:0];
    assign irq_o   = tick_irq_q;

endmodule

//--- rdata_mux.sv
`timescale 1ns/10ps

module rdata_mux import soc_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  dec_req_t    dec_i,
    input  logic [31:0] ram_rdata_i,
    input  logic [31:0] io_rdata_i,
    output dbus_rsp_t   rsp_o
);

    target_e     tgt_q;
    logic        rd_q;
    logic        wr_q;
    logic [3:0]  be_q;
    logic [31:0] lane_mask;
    logic [31:0] word;
    dbus_rsp_t   rsp_next;

    // lines the request up with the registered read words of the execute stage
    always_ff @(posedge clk) begin
        tgt_q <= dec_i.target;
        be_q  <= dec_i.be;
        if (rst_i) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= dec_i.rd;
            wr_q <= dec_i.wr;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_mask[8*i +: 8] = {8{be_q[i]}};
        end
        word = (tgt_q == TGT_RAM) ? ram_rdata_i : io_rdata_i;

        rsp_next.valid = rd_q || wr_q;
        rsp_next.err   = rsp_next.valid && (tgt_q == TGT_NONE);
        if (rd_q && tgt_q != TGT_NONE) begin
            rsp_next.rdata = word & lane_mask;
        end else begin
            rsp_next.rdata = '0;    // writes and errors return zero
        end
    end

    always_ff @(posedge clk) begin
        rsp_o <= rsp_next;
        if (rst_i) begin
            rsp_o.valid <= 1'b0;
            rsp_o.err   <= 1'b0;
        end
    end

    // dec_i lags the bus request by one edge, so two here means three on the bus
    a_rsp_latency: assert property (@(posedge clk) disable iff (rst_i)
        rsp_o.valid |-> $past(dec_i.rd || dec_i.wr, 2));

endmodule

//--- soc_bus_golden.txt
# first data line: gpio_i pin value (hex)
# then one request per line: op(R/W) addr be wdata expected_rdata expected_err (hex)
3c5a96e1
W 00000010 f 11223344 00000000 0
W 00000010 6 aabbccdd 00000000 0
R 00000010 f 00000000 11bbcc44 0
R 00000010 3 00000000 0000cc44 0
R 00000010 c 00000000 11bb0000 0
R 00000010 9 00000000 11000044 0
W 00000000 f 0badf00d 00000000 0
W 00000400 f deadbeef 00000000 1
W 10000200 f 12345678 00000000 1
R 10000200 f 00000000 00000000 1
R 20000000 f 00000000 00000000 1
R 00000000 f 00000000 0badf00d 0
W 10000000 1 0000a5c3 00000000 0
R 10000000 f 00000000 0000a5c3 0
R 10000004 f 00000000 3c5a96e1 0
R 10000004 6 00000000 005a9600 0
W 10000104 f 12345678 00000000 0
R 10000104 f 00000000 12345678 0
W 10000104 f 00000000 00000000 0
W 10000108 f 00000020 00000000 0
W 10000100 f 00000001 00000000 0
R 10000100 f 00000000 00000003 0
W 10000100 f 00000002 00000000 0
R 10000100 f 00000000 00000000 0

//--- soc_bus_pkg.sv
package soc_bus_pkg;

    // address map, region is addr[31:28]
    localparam logic [3:0] REGION_RAM = 4'h0;
    localparam logic [3:0] REGION_IO  = 4'h1;

    // device numbers inside the io region
    localparam logic [7:0] DEV_GPIO = 8'h00;
    localparam logic [7:0] DEV_TICK = 8'h01;

    // gpio register indices
    localparam logic [5:0] REG_GPIO_OUT = 6'd0;
    localparam logic [5:0] REG_GPIO_IN  = 6'd1;

    // tick counter register indices
    localparam logic [5:0] REG_TICK_CTRL  = 6'd0;
    localparam logic [5:0] REG_TICK_COUNT = 6'd1;
    localparam logic [5:0] REG_TICK_CMP   = 6'd2;

    // one address word, seen either as a ram word address or as an io register address
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [25:0] word_index;
            logic [1:0]  byte_offset;
        } ram;
        struct packed {
            logic [3:0]  region;
            logic [11:0] unused;
            logic [7:0]  device;
            logic [5:0]  reg_index;
            logic [1:0]  byte_offset;
        } io;
    } dbus_addr_u;

    typedef struct packed {
        logic        rd;
        logic        wr;
        dbus_addr_u  addr;
        logic [3:0]  be;
        logic [31:0] wdata;
    } dbus_req_t;

    typedef enum logic [1:0] {
        TGT_RAM  = 2'd0,
        TGT_GPIO = 2'd1,
        TGT_TICK = 2'd2,
        TGT_NONE = 2'd3
    } target_e;

    typedef struct packed {
        logic        rd;
        logic        wr;
        target_e     target;
        logic [25:0] word_index;
        logic [5:0]  reg_index;
        logic [3:0]  be;
        logic [31:0] wdata;
    } dec_req_t;

    typedef struct packed {
        logic        valid;
        logic        err;   // unmapped address
        logic [31:0] rdata;
    } dbus_rsp_t;

endpackage

//--- soc_bus_top.f
soc_bus_pkg.sv
dbus_decode.sv
data_ram.sv
io_regs.sv
rdata_mux.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top import soc_bus_pkg::*; #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_i,
    input  dbus_req_t   req_i,
    input  logic [31:0] gpio_i,
    output dbus_rsp_t   rsp_o,
    output logic [15:0] leds_o,
    output logic        irq_o
);

    dec_req_t    dec;
    logic [31:0] ram_rdata;
    logic [31:0] io_rdata;

    dbus_decode #(
        .RAM_WORDS(RAM_WORDS)
    ) decode_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (req_i),
        .dec_o (dec)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram_inst (
        .clk     (clk),
        .dec_i   (dec),
        .rdata_o (ram_rdata)
    );

    io_regs io_inst (
        .clk     (clk),
        .rst_i   (rst_i),
        .dec_i   (dec),
        .gpio_i  (gpio_i),
        .rdata_o (io_rdata),
        .leds_o  (leds_o),
        .irq_o   (irq_o)
    );

    rdata_mux result_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_i       (dec),
        .ram_rdata_i (ram_rdata),
        .io_rdata_i  (io_rdata),
        .rsp_o       (rsp_o)
    );

endmodule

//--- tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus import soc_bus_pkg::*; ();

    localparam logic [31:0] GPIO_OUT_ADDR  = 32'h1000_0000;
    localparam logic [31:0] TICK_CTRL_ADDR = 32'h1000_0100;
    localparam int          RSP_DELAY      = 4;  // negedges from the driving edge to the response

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        dbus_rsp_t   rsp;   // expected response
    } vec_t;

    typedef struct packed {
        vec_t v;
        int   stamp;
    } pending_t;

    logic        clk = 1'b0;
    logic        rst_i;
    dbus_req_t   req_i;
    logic [31:0] gpio_i;
    dbus_rsp_t   rsp_o;
    logic [15:0] leds_o;
    logic        irq_o;

    vec_t        vec_q[$];
    pending_t    exp_q[$];
    pending_t    sent;
    pending_t    cur;
    logic [31:0] lfsr_q = 32'hf8b9f911;
    int          ncyc = 0;
    int          gap;
    int          back_to_back = 0;
    int          wd_limit;
    bit          loaded = 1'b0;

    soc_bus_top #(
        .RAM_WORDS(256)
    ) DUT (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .gpio_i (gpio_i),
        .rsp_o  (rsp_o),
        .leds_o (leds_o),
        .irq_o  (irq_o)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_rsp(input dbus_rsp_t got, input dbus_rsp_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: rsp_o got %b %b %h, expected %b %b %h (valid err rdata)",
                     $time, got.valid, got.err, got.rdata, exp.valid, exp.err, exp.rdata);
            abort_run();
        end
    endtask

    task automatic check_leds(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: leds_o got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: irq_o got %b expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t ns: rsp_o latency got %0d expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_gap(output int g);
        g = 0;
        for (int k = 0; k < 2; k++) begin
            g = (g << 1) | int'(lfsr_q[31]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic dbus_req_t make_req(input vec_t v);
        dbus_req_t req;
        req.rd    = (v.op == "R");
        req.wr    = (v.op == "W");
        req.addr  = v.addr;
        req.be    = v.be;
        req.wdata = v.wdata;
        return req;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        bit          have_gpio;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] r;
        logic [3:0]  b;
        logic        e;
        vec_t        v;
        have_gpio = 1'b0;
        fd = $fopen("soc_bus_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open soc_bus_golden.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (!have_gpio) begin
                n = $sscanf(line, "%h", gpio_i);     // first data line is the pin value
                have_gpio = 1'b1;
            end else begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", a, b, w, r, e);
                if (n != 5 || (line.getc(0) != "R" && line.getc(0) != "W")) begin
                    $display("malformed vector line in soc_bus_golden.txt: %s", line);
                    abort_run();
                end
                v.op        = line.getc(0);
                v.addr      = a;
                v.be        = b;
                v.wdata     = w;
                v.rsp.valid = 1'b1;
                v.rsp.err   = e;
                v.rsp.rdata = r;
                vec_q.push_back(v);
            end
        end
        $fclose(fd);
        if (vec_q.size() == 0) begin
            $display("soc_bus_golden.txt holds no request vectors");
            abort_run();
        end
    endtask

    task automatic wait_irq();
        @(negedge clk);
        while (irq_o !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst_i  = 1'b1;
        req_i  = '0;
        gpio_i = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_leds(leds_o, 16'h0000);
        check_irq(irq_o, 1'b0);
        foreach (vec_q[i]) begin
            @(posedge clk);
            req_i      <= make_req(vec_q[i]);
            if (exp_q.size() != 0 && exp_q[$].stamp == ncyc - 1) begin
                back_to_back++;     // the previous request went out on the edge before
            end
            sent.v     = vec_q[i];
            sent.stamp = ncyc;
            exp_q.push_back(sent);
            draw_gap(gap);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                req_i <= '0;
            end
            // enabling the counter holds the bus idle until the compare fires
            if (vec_q[i].op == "W" && vec_q[i].addr == TICK_CTRL_ADDR && vec_q[i].wdata[0]) begin
                if (gap == 0) begin
                    @(posedge clk);
                    req_i <= '0;
                end
                wait_irq();
            end
        end
        @(posedge clk);
        req_i <= '0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (back_to_back == 0) begin
            $display("no two requests were sent in consecutive cycles");
            abort_run();
        end else begin
            $display("%0d of %0d requests were sent back to back", back_to_back, vec_q.size());
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // responses are sampled half a cycle after the edge that registers them
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (!rst_i && rsp_o.valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                $display("a response arrived at %0t ns with no request outstanding", $time);
                abort_run();
            end
            cur = exp_q.pop_front();
            check_latency(ncyc - cur.stamp, RSP_DELAY);
            check_rsp(rsp_o, cur.v.rsp);
            if (cur.v.op == "W" && cur.v.addr == GPIO_OUT_ADDR) begin
                check_leds(leds_o, cur.v.wdata[15:0]);
            end
            if (cur.v.op == "W" && cur.v.addr == TICK_CTRL_ADDR && cur.v.wdata[1]) begin
                check_irq(irq_o, 1'b0);  // write one to clear has taken effect
            end
        end
    end

    initial begin
        while (!loaded) begin
            @(posedge clk);
        end
        wd_limit = vec_q.size() * 4 + 200;
        repeat (wd_limit) @(posedge clk);
        $display("timeout after %0d cycles: responses or the tick interrupt never arrived",
                 wd_limit);
        abort_run();
    end

endmodule
